// File: sources.f
source/fft_pkg.sv
source/complex_multiplier.sv
source/multi_butterfly.sv
source/pease_fft.sv
tb/clock_gen.sv
tb/pease_fft_checker.sv
tb/pease_fft_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the pease fft testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module pease_fft_tb \
  -f sources.f \
  -o pease_fft_sim

# a failing run still leaves its log for the search below
./obj_dir/pease_fft_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// File: tb/pease_fft_tb.sv
// pease fft testbench
`timescale 1ns/1ns

module pease_fft_tb;

  typedef logic [fft_pkg::data_width-1:0] word_t;

  // about 16 cycles per transform plus room for back-pressure
  localparam int cycles_per_transform = 40;
  // impulse and constant frames plus the random ones and two back-pressure frames
  localparam int num_random = 20;
  localparam int num_transforms = num_random + 4;
  localparam int watchdog_cycles = cycles_per_transform * num_transforms + 10;
  localparam int wait_limit = 40;
  // 1.0 in the fixed-point format
  localparam int one_q = 1 << fft_pkg::frac_bits;

  logic clk;
  logic reset;
  logic recv_val;
  logic recv_rdy;
  logic send_val;
  logic send_rdy;
  word_t stim_re [fft_pkg::num_points];
  word_t stim_im [fft_pkg::num_points];
  word_t out_re [fft_pkg::num_points];
  word_t out_im [fft_pkg::num_points];
  word_t exp_re [fft_pkg::num_points];
  word_t exp_im [fft_pkg::num_points];

  clock_gen i_clock_gen (
    .clk  (clk),
    .reset(reset)
  );

  pease_fft i_pease_fft (
    .clk     (clk),
    .reset   (reset),
    .recv_val(recv_val),
    .recv_rdy(recv_rdy),
    .in_re   (stim_re),
    .in_im   (stim_im),
    .send_val(send_val),
    .send_rdy(send_rdy),
    .out_re  (out_re),
    .out_im  (out_im)
  );

  // ==========================================================================
  // reporting and reference model
  // ==========================================================================

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_value(input string test_name, input string item,
                               input word_t expected, input word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH %s %s expected %h actual %h",
                          test_name, item, expected, actual));
    end
  endtask

  // keep the low data_width bits and sign extend them again
  function automatic longint wrap_word(input longint value);
    logic signed [fft_pkg::data_width-1:0] low_bits;
    low_bits = value[fft_pkg::data_width-1:0];
    return longint'(low_bits);
  endfunction

  // three pease stages in plain integers from stim to exp
  function automatic void run_model();
    longint cur_re [fft_pkg::num_points];
    longint cur_im [fft_pkg::num_points];
    longint nxt_re [fft_pkg::num_points];
    longint nxt_im [fft_pkg::num_points];
    longint a_re;
    longint a_im;
    longint b_re;
    longint b_im;
    longint w_re;
    longint w_im;
    longint p_re;
    longint p_im;
    int low;
    int k;
    for (int i = 0; i < fft_pkg::num_points; i++) begin
      cur_re[i] = longint'($signed(stim_re[i]));
      cur_im[i] = longint'($signed(stim_im[i]));
    end
    for (int s = 0; s < fft_pkg::num_stages; s++) begin
      // exponent is j with its low (2 - s) bits cleared
      low = fft_pkg::num_stages - 1 - s;
      for (int j = 0; j < fft_pkg::num_butterflies; j++) begin
        k = (j >> low) << low;
        w_re = longint'(fft_pkg::twiddle_re[k]);
        w_im = longint'(fft_pkg::twiddle_im[k]);
        a_re = cur_re[2*j];
        a_im = cur_im[2*j];
        b_re = cur_re[2*j+1];
        b_im = cur_im[2*j+1];
        // full precision product with a floor shift and then a wrap
        p_re = wrap_word((b_re * w_re - b_im * w_im) >>> fft_pkg::frac_bits);
        p_im = wrap_word((b_re * w_im + b_im * w_re) >>> fft_pkg::frac_bits);
        nxt_re[j] = wrap_word(a_re + p_re);
        nxt_im[j] = wrap_word(a_im + p_im);
        nxt_re[j + fft_pkg::num_butterflies] = wrap_word(a_re - p_re);
        nxt_im[j + fft_pkg::num_butterflies] = wrap_word(a_im - p_im);
      end
      cur_re = nxt_re;
      cur_im = nxt_im;
    end
    for (int i = 0; i < fft_pkg::num_points; i++) begin
      exp_re[i] = word_t'(cur_re[i]);
      exp_im[i] = word_t'(cur_im[i]);
    end
  endfunction

  // ==========================================================================
  // handshake helpers entered 1 ns after a rising edge
  // ==========================================================================

  task automatic wait_ready(input string test_name);
    int waited;
    waited = 0;
    while (!recv_rdy) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > wait_limit) begin
        abort_run($sformatf("%s: DUT never raised recv_rdy", test_name));
      end
    end
  endtask

  task automatic drive_input(input string test_name);
    recv_val = 1'b1;
    wait_ready(test_name);
    // transfer happens on this edge
    @(posedge clk);
    #1;
    recv_val = 1'b0;
  endtask

  task automatic wait_output(input string test_name);
    int waited;
    waited = 0;
    while (!send_val) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > wait_limit) begin
        abort_run($sformatf("%s: DUT never raised send_val", test_name));
      end
    end
  endtask

  task automatic release_output(input string test_name);
    send_rdy = 1'b1;
    @(posedge clk);
    #1;
    send_rdy = 1'b0;
    compare_value(test_name, "send_val after transfer", '0, word_t'(send_val));
  endtask

  task automatic verify_bins(input string test_name);
    for (int i = 0; i < fft_pkg::num_points; i++) begin
      compare_value(test_name, $sformatf("out_re[%0d]", i), exp_re[i], out_re[i]);
      compare_value(test_name, $sformatf("out_im[%0d]", i), exp_im[i], out_im[i]);
    end
  endtask

  // each part in -4095..4095 so below 1.0
  task automatic fill_random();
    int value;
    for (int i = 0; i < fft_pkg::num_points; i++) begin
      value = int'($urandom_range(2 * one_q - 2)) - (one_q - 1);
      stim_re[i] = word_t'(value);
      value = int'($urandom_range(2 * one_q - 2)) - (one_q - 1);
      stim_im[i] = word_t'(value);
    end
  endtask

  // ==========================================================================
  // directed tests
  // ==========================================================================

  task automatic reset_state();
    @(posedge clk);
    #1;
    // reset still high here
    compare_value("reset", "recv_rdy in reset", '0, word_t'(recv_rdy));
    compare_value("reset", "send_val in reset", '0, word_t'(send_val));
    @(negedge reset);
    @(posedge clk);
    #1;
    wait_ready("reset");
    compare_value("reset", "send_val after reset", '0, word_t'(send_val));
  endtask

  // 1.0 at position 0 gives a flat spectrum of 1.0
  task automatic impulse_response();
    for (int i = 0; i < fft_pkg::num_points; i++) begin
      stim_re[i] = '0;
      stim_im[i] = '0;
      exp_re[i] = word_t'(one_q);
      exp_im[i] = '0;
    end
    stim_re[0] = word_t'(one_q);
    drive_input("impulse");
    wait_output("impulse");
    verify_bins("impulse");
    release_output("impulse");
  endtask

  // 0.5 everywhere sums to 8 * 0.5 = 4.0 in position 0
  task automatic constant_input();
    for (int i = 0; i < fft_pkg::num_points; i++) begin
      stim_re[i] = word_t'(one_q / 2);
      stim_im[i] = '0;
      exp_re[i] = '0;
      exp_im[i] = '0;
    end
    exp_re[0] = word_t'(4 * one_q);
    drive_input("constant");
    wait_output("constant");
    verify_bins("constant");
    release_output("constant");
  endtask

  task automatic random_frames();
    string name;
    for (int n = 0; n < num_random; n++) begin
      name = $sformatf("random_%0d", n);
      fill_random();
      run_model();
      drive_input(name);
      wait_output(name);
      verify_bins(name);
      release_output(name);
    end
  endtask

  // result held while the next frame is already offered
  task automatic backpressure_hold();
    word_t hold_re [fft_pkg::num_points];
    word_t hold_im [fft_pkg::num_points];
    int hold_cycles;
    hold_cycles = int'($urandom_range(10));
    fill_random();
    run_model();
    drive_input("backpressure");
    wait_output("backpressure");
    verify_bins("backpressure");
    hold_re = exp_re;
    hold_im = exp_im;
    fill_random();
    run_model();
    recv_val = 1'b1;
    repeat (hold_cycles) begin
      @(posedge clk);
      #1;
      compare_value("backpressure", "send_val held", word_t'(1), word_t'(send_val));
      compare_value("backpressure", "recv_rdy held", '0, word_t'(recv_rdy));
      for (int i = 0; i < fft_pkg::num_points; i++) begin
        compare_value("backpressure", $sformatf("held out_re[%0d]", i), hold_re[i], out_re[i]);
        compare_value("backpressure", $sformatf("held out_im[%0d]", i), hold_im[i], out_im[i]);
      end
    end
    release_output("backpressure");
    // the pending frame goes in only now
    drive_input("after_backpressure");
    wait_output("after_backpressure");
    verify_bins("after_backpressure");
    release_output("after_backpressure");
  endtask

  // ==========================================================================
  // run control
  // ==========================================================================

  initial begin
    recv_val = 1'b0;
    send_rdy = 1'b0;
    for (int i = 0; i < fft_pkg::num_points; i++) begin
      stim_re[i] = '0;
      stim_im[i] = '0;
    end
    void'($urandom(32'h0b56d562));
    reset_state();
    impulse_response();
    constant_input();
    random_frames();
    backpressure_hold();
    if (i_pease_fft.i_checker.fail_count == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abort_run("assertion failure in pease_fft_checker");
    end
  end

  // assertion failures end the run at the next falling edge
  always @(negedge clk) begin
    if (i_pease_fft.i_checker.fail_count != 0) begin
      abort_run("assertion failure in pease_fft_checker");
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    abort_run("watchdog expired before the tests finished");
  end

endmodule

// File: tb/pease_fft_checker.sv
// pease fft handshake assertions
`timescale 1ns/1ns

module pease_fft_checker (
  input logic clk,
  input logic reset,
  input logic recv_rdy,
  input logic send_val,
  input logic send_rdy,
  input logic [$clog2(fft_pkg::num_stages)-1:0] stage,
  input logic [fft_pkg::data_width-1:0] out_re [fft_pkg::num_points],
  input logic [fft_pkg::data_width-1:0] out_im [fft_pkg::num_points]
);

  // failure counts, one per assertion
  int hold_fails = 0;
  int excl_fails = 0;
  int stage_fails = 0;
  int fail_count;

  // all bins in one vector for $stable
  logic [2*fft_pkg::num_points*fft_pkg::data_width-1:0] out_flat;

  assign fail_count = hold_fails + excl_fails + stage_fails;

  always_comb begin
    for (int i = 0; i < fft_pkg::num_points; i++) begin
      out_flat[2*i*fft_pkg::data_width +: fft_pkg::data_width] = out_re[i];
      out_flat[(2*i+1)*fft_pkg::data_width +: fft_pkg::data_width] = out_im[i];
    end
  end

  // result waits, unchanged, for the sink
  hold_until_taken: assert property (@(posedge clk) disable iff (reset)
    send_val && !send_rdy |=> send_val && $stable(out_flat))
  else begin
    $error("send_val dropped or bins changed before send_rdy");
    hold_fails++;
  end

  // a new frame is never taken while a result is pending
  ready_or_valid: assert property (@(posedge clk) disable iff (reset)
    !(recv_rdy && send_val))
  else begin
    $error("recv_rdy and send_val high together");
    excl_fails++;
  end

  stage_in_range: assert property (@(posedge clk) disable iff (reset)
    stage < 2'(fft_pkg::num_stages))
  else begin
    $error("stage counter out of range");
    stage_fails++;
  end

endmodule

bind pease_fft pease_fft_checker i_checker (
  .clk     (clk),
  .reset   (reset),
  .recv_rdy(recv_rdy),
  .send_val(send_val),
  .send_rdy(send_rdy),
  .stage   (stage),
  .out_re  (out_re),
  .out_im  (out_im)
);

// File: tb/clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ns

module clock_gen (
  output logic clk,
  output logic reset
);

  // 4 ns period
  localparam int half_period_ns = 2;
  localparam int reset_cycles = 3;

  initial begin
    clk = 1'b0;
    forever #half_period_ns clk = ~clk;
  end

  // release just after an edge, like the rest of the stimulus
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

// File: source/pease_fft.sv
// pease fft top level
`timescale 1ns/1ns

module pease_fft (
  input  logic clk,
  input  logic reset,

  // sample input, all points in one transfer
  input  logic recv_val,
  output logic recv_rdy,
  input  logic [fft_pkg::data_width-1:0] in_re [fft_pkg::num_points],
  input  logic [fft_pkg::data_width-1:0] in_im [fft_pkg::num_points],

  // bin output, all points in one transfer
  output logic send_val,
  input  logic send_rdy,
  output logic [fft_pkg::data_width-1:0] out_re [fft_pkg::num_points],
  output logic [fft_pkg::data_width-1:0] out_im [fft_pkg::num_points]
);

  // INIT holds recv_rdy low through reset
  typedef enum logic [2:0] {
    INIT,
    IDLE,
    ISSUE,
    BUSY,
    DONE
  } state_t;

  state_t state;
  logic [$clog2(fft_pkg::num_stages)-1:0] stage;

  // sample memory, rewritten in place by every stage
  logic [fft_pkg::data_width-1:0] mem_re [fft_pkg::num_points];
  logic [fft_pkg::data_width-1:0] mem_im [fft_pkg::num_points];

  // butterfly unit handshake
  logic bf_recv_val;
  logic bf_recv_rdy;
  logic bf_send_val;
  logic bf_send_rdy;

  // butterfly operands and results
  logic [fft_pkg::data_width-1:0] bf_ar [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] bf_ac [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] bf_br [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] bf_bc [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] bf_wr [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] bf_wc [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] bf_cr [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] bf_cc [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] bf_dr [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] bf_dc [fft_pkg::num_butterflies];

  // twiddle exponent per butterfly, and the mask of bits kept this stage
  logic [1:0] tw_mask;
  logic [1:0] tw_exp [fft_pkg::num_butterflies];

  assign recv_rdy    = (state == IDLE);
  assign send_val    = (state == DONE);
  assign bf_recv_val = (state == ISSUE);
  assign bf_send_rdy = (state == BUSY);

  // ==========================================================================
  // stage wiring, identical for every stage
  // ==========================================================================

  // stage s clears the low (2 - s) bits of j
  assign tw_mask = 2'b11 << (2'(fft_pkg::num_stages - 1) - stage);

  // butterfly j reads 2j and 2j+1
  always_comb begin
    for (int j = 0; j < fft_pkg::num_butterflies; j++) begin
      tw_exp[j] = 2'(j) & tw_mask;
      bf_ar[j]  = mem_re[2*j];
      bf_ac[j]  = mem_im[2*j];
      bf_br[j]  = mem_re[2*j+1];
      bf_bc[j]  = mem_im[2*j+1];
      bf_wr[j]  = fft_pkg::twiddle_re[tw_exp[j]];
      bf_wc[j]  = fft_pkg::twiddle_im[tw_exp[j]];
    end
  end

  multi_butterfly i_multi_butterfly (
    .clk     (clk),
    .reset   (reset),
    .recv_val(bf_recv_val),
    .recv_rdy(bf_recv_rdy),
    .send_val(bf_send_val),
    .send_rdy(bf_send_rdy),
    .ar      (bf_ar),
    .ac      (bf_ac),
    .br      (bf_br),
    .bc      (bf_bc),
    .wr      (bf_wr),
    .wc      (bf_wc),
    .cr      (bf_cr),
    .cc      (bf_cc),
    .dr      (bf_dr),
    .dc      (bf_dc)
  );

  // ==========================================================================
  // memory and control
  // ==========================================================================

  // load on input transfer, otherwise c goes to j and d goes to j+4
  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      mem_re <= in_re;
      mem_im <= in_im;
    end else if (bf_send_val && bf_send_rdy) begin
      for (int j = 0; j < fft_pkg::num_butterflies; j++) begin
        mem_re[j] <= bf_cr[j];
        mem_im[j] <= bf_cc[j];
        mem_re[j + fft_pkg::num_butterflies] <= bf_dr[j];
        mem_im[j + fft_pkg::num_butterflies] <= bf_dc[j];
      end
    end
  end

  // per stage: one issue cycle, then BUSY until the results return
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= INIT;
      stage <= '0;
    end else begin
      case (state)
        INIT: state <= IDLE;
        IDLE: begin
          if (recv_val) begin
            state <= ISSUE;
          end
        end
        ISSUE: begin
          if (bf_recv_rdy) begin
            state <= BUSY;
          end
        end
        BUSY: begin
          if (bf_send_val) begin
            if (stage == 2'(fft_pkg::num_stages - 1)) begin
              stage <= '0;
              state <= DONE;
            end else begin
              stage <= stage + 2'd1;
              state <= ISSUE;
            end
          end
        end
        // memory is frozen here, so the bins stay stable
        DONE: begin
          if (send_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= INIT;
      endcase
    end
  end

  // bins come straight from the memory after the last stage
  assign out_re = mem_re;
  assign out_im = mem_im;

endmodule

// File: source/multi_butterfly.sv
// buffered multi-butterfly unit
`timescale 1ns/1ns

module multi_butterfly (
  input  logic clk,
  input  logic reset,
  input  logic recv_val,
  output logic recv_rdy,
  output logic send_val,
  input  logic send_rdy,

  // operands, one entry per butterfly
  input  logic [fft_pkg::data_width-1:0] ar [fft_pkg::num_butterflies],
  input  logic [fft_pkg::data_width-1:0] ac [fft_pkg::num_butterflies],
  input  logic [fft_pkg::data_width-1:0] br [fft_pkg::num_butterflies],
  input  logic [fft_pkg::data_width-1:0] bc [fft_pkg::num_butterflies],
  input  logic [fft_pkg::data_width-1:0] wr [fft_pkg::num_butterflies],
  input  logic [fft_pkg::data_width-1:0] wc [fft_pkg::num_butterflies],

  // results, c = a + w*b and d = a - w*b
  output logic [fft_pkg::data_width-1:0] cr [fft_pkg::num_butterflies],
  output logic [fft_pkg::data_width-1:0] cc [fft_pkg::num_butterflies],
  output logic [fft_pkg::data_width-1:0] dr [fft_pkg::num_butterflies],
  output logic [fft_pkg::data_width-1:0] dc [fft_pkg::num_butterflies]
);

  typedef enum logic [1:0] {
    IDLE,
    COMP,
    DONE
  } state_t;

  state_t state;

  // rotation step, each multiplier visits two butterflies
  logic rot;

  // buffered operands
  logic [fft_pkg::data_width-1:0] s_ar [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] s_ac [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] s_br [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] s_bc [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] s_wr [fft_pkg::num_butterflies];
  logic [fft_pkg::data_width-1:0] s_wc [fft_pkg::num_butterflies];

  // butterfly served by each multiplier in the current step
  logic [$clog2(fft_pkg::num_butterflies)-1:0] sel [fft_pkg::num_mults];

  // products w*b from the shared multipliers
  logic [fft_pkg::data_width-1:0] m_cr [fft_pkg::num_mults];
  logic [fft_pkg::data_width-1:0] m_cc [fft_pkg::num_mults];

  assign recv_rdy = (state == IDLE);
  assign send_val = (state == DONE);

  // ==========================================================================
  // shared multipliers
  // ==========================================================================

  for (genvar gi = 0; gi < fft_pkg::num_mults; gi++) begin : g_mult
    // multiplier gi covers butterflies 2*gi and 2*gi+1
    assign sel[gi] = {1'(gi), rot};

    complex_multiplier i_mult (
      .ar(s_br[sel[gi]]),
      .ac(s_bc[sel[gi]]),
      .br(s_wr[sel[gi]]),
      .bc(s_wc[sel[gi]]),
      .cr(m_cr[gi]),
      .cc(m_cc[gi])
    );
  end

  // ==========================================================================
  // datapath
  // ==========================================================================

  // take a full set of operands on the input transfer
  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      s_ar <= ar;
      s_ac <= ac;
      s_br <= br;
      s_bc <= bc;
      s_wr <= wr;
      s_wc <= wc;
    end
  end

  // each compute step retires one butterfly per multiplier
  // sums wrap at data_width
  always_ff @(posedge clk) begin
    if (state == COMP) begin
      for (int i = 0; i < fft_pkg::num_mults; i++) begin
        cr[sel[i]] <= s_ar[sel[i]] + m_cr[i];
        cc[sel[i]] <= s_ac[sel[i]] + m_cc[i];
        dr[sel[i]] <= s_ar[sel[i]] - m_cr[i];
        dc[sel[i]] <= s_ac[sel[i]] - m_cc[i];
      end
    end
  end

  // ==========================================================================
  // control
  // ==========================================================================

  // IDLE -> COMP for two steps -> DONE until the sink takes the results
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      rot   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (recv_val) begin
            state <= COMP;
          end
        end
        COMP: begin
          rot <= ~rot;
          // second step done
          if (rot) begin
            state <= DONE;
          end
        end
        DONE: begin
          if (send_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: source/complex_multiplier.sv
// fixed-point complex multiplier
`timescale 1ns/1ns

module complex_multiplier (
  input  logic [fft_pkg::data_width-1:0] ar,
  input  logic [fft_pkg::data_width-1:0] ac,
  input  logic [fft_pkg::data_width-1:0] br,
  input  logic [fft_pkg::data_width-1:0] bc,
  output logic [fft_pkg::data_width-1:0] cr,
  output logic [fft_pkg::data_width-1:0] cc
);

  // operand sums need one extra bit
  logic signed [fft_pkg::data_width:0] sum_a;
  logic signed [fft_pkg::data_width:0] diff_b;
  logic signed [fft_pkg::data_width:0] sum_b;

  // full precision products and combinations, 34 bits
  logic signed [2*fft_pkg::data_width+1:0] k1;
  logic signed [2*fft_pkg::data_width+1:0] k2;
  logic signed [2*fft_pkg::data_width+1:0] k3;
  logic signed [2*fft_pkg::data_width+1:0] full_re;
  logic signed [2*fft_pkg::data_width+1:0] full_im;

  // gauss form, three multipliers instead of four
  // k1 = br*(ar+ac), k2 = ar*(bc-br), k3 = ac*(br+bc)
  always_comb begin
    sum_a  = $signed(ar) + $signed(ac);
    diff_b = $signed(bc) - $signed(br);
    sum_b  = $signed(br) + $signed(bc);
    k1 = $signed(br) * sum_a;
    k2 = $signed(ar) * diff_b;
    k3 = $signed(ac) * sum_b;
    // exact at full width, same as ar*br - ac*bc and ar*bc + ac*br
    full_re = k1 - k3;
    full_im = k1 + k2;
  end

  // floor shift back to the fixed-point grid, keep the low bits (wraps)
  assign cr = fft_pkg::data_width'(full_re >>> fft_pkg::frac_bits);
  assign cc = fft_pkg::data_width'(full_im >>> fft_pkg::frac_bits);

endmodule

// File: source/fft_pkg.sv
// fft shared constants
package fft_pkg;

  // ==========================================================================
  // number format
  // ==========================================================================

  // one real or imaginary part, two's complement
  localparam int data_width = 16;
  // fractional bits, also the shift applied after every product
  localparam int frac_bits = 12;

  // ==========================================================================
  // transform geometry
  // ==========================================================================

  localparam int num_points = 8;
  // log2 of num_points
  localparam int num_stages = 3;
  // radix-2, so half the points per stage
  localparam int num_butterflies = num_points / 2;
  // complex multipliers shared by the butterflies
  localparam int num_mults = 2;

  // ==========================================================================
  // twiddle table
  // ==========================================================================

  // e^(-2*pi*i*k/8) for k = 0..3, rounded to frac_bits
  // real part is cos, imaginary part is -sin
  localparam logic signed [data_width-1:0] twiddle_re [num_points/2] = '{
    16'sd4096, 16'sd2896, 16'sd0, -16'sd2896
  };
  localparam logic signed [data_width-1:0] twiddle_im [num_points/2] = '{
    16'sd0, -16'sd2896, -16'sd4096, -16'sd2896
  };

endpackage
